// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_gb_cart_mapper
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Checks failed
PASS_MSG = All checks passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+verilog
verilog/gb_cart_pkg.sv
verilog/cart_bus_if.sv
verilog/cart_header_capture.sv
verilog/mbc_registers.sv
verilog/rom_bank_mapper.sv
verilog/cart_ram.sv
verilog/gb_cart_mapper.sv
testbench/gb_cart_asserts.sv
testbench/tb_gb_cart_mapper.sv

// File: testbench/gb_cart_asserts.sv
`timescale 1ns/1ns

// bus protocol checks, bound into gb_cart_mapper
module gb_cart_asserts (
	input logic                    clk_sys,
	input logic                    reset,
	input gb_cart_pkg::cart_addr_t cart_addr,
	input logic                    cart_rd,
	input logic                    cart_wr,
	input logic                    sdram_rd,
	input logic                    cart_ready,  // internal to the top level
	input gb_cart_pkg::cart_byte_t cart_do
);

	// cpu never reads and writes in one cycle
	rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(cart_rd && cart_wr)
	) else $error("cart_rd and cart_wr high in the same cycle");

	// external rom is only fetched below 8000
	rom_window_only: assert property (
		@(posedge clk_sys) disable iff (reset) sdram_rd |-> !cart_addr[15]
	) else $error("sdram_rd raised for address %h", cart_addr);

	// unloaded cartridge reads as 00
	unloaded_reads_zero: assert property (
		@(posedge clk_sys) disable iff (reset)
		(cart_rd && !cart_ready) |=> (cart_do == 8'h00)
	) else $error("cart_do is %h after a read of an unloaded cartridge", cart_do);

endmodule

// File: testbench/tb_gb_cart_mapper.sv
`timescale 1ns/1ns
`include "gb_cart_defs.svh"

module tb_gb_cart_mapper;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam gb_cart_pkg::rom_word_t ROM_XOR = 16'h5A3C;  // sdram model pattern
	// cycle budget of each test in run order
	localparam int RUN_CYCLES = RESET_CYCLES + 40 + 80 + 60 + 80 + 40 + 100;

	logic                     clk_sys;
	logic                     reset;
	logic                     dl_active;
	logic                     dl_wr;
	logic [`DL_ADDR_W-1:0]    dl_addr;
	gb_cart_pkg::rom_word_t   dl_data;
	gb_cart_pkg::cart_addr_t  cart_addr;
	gb_cart_pkg::cart_byte_t  cart_di;
	logic                     cart_rd;
	logic                     cart_wr;
	gb_cart_pkg::cart_byte_t  cart_do;
	gb_cart_pkg::sdram_addr_t sdram_addr;
	logic                     sdram_rd;
	gb_cart_pkg::rom_word_t   rom_data;

	int          errors;
	int          checks;
	logic [15:0] lfsr_state;

	gb_cart_mapper gb_cart_mapper_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.cart_addr  (cart_addr),
		.cart_di    (cart_di),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_do    (cart_do),
		.sdram_addr (sdram_addr),
		.sdram_rd   (sdram_rd),
		.rom_data   (rom_data)
	);

	bind gb_cart_mapper gb_cart_asserts gb_cart_asserts_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.sdram_rd   (sdram_rd),
		.cart_ready (cart_ready),
		.cart_do    (cart_do)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	assign rom_data = sdram_addr[15:0] ^ ROM_XOR;  // rom word valid in the same cycle

	// ------------------------------------------------------------------------
	// models and helpers
	// ------------------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;  // galois taps 16,14,13,11
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// 16 KB bank and 8 KB half above the word offset inside the half
	function automatic gb_cart_pkg::sdram_addr_t expected_word_addr(
		input gb_cart_pkg::cart_addr_t addr, input logic [8:0] bank);
		logic [9:0] field;
		if (addr[15:14] == 2'b01)
			field = {bank, addr[13]};
		else
			field = {9'd0, addr[13]};  // fixed window is bank 0
		return {2'b00, field, addr[12:1]};
	endfunction

	function automatic gb_cart_pkg::cart_byte_t rom_model_byte(
		input gb_cart_pkg::sdram_addr_t waddr, input logic odd);
		gb_cart_pkg::rom_word_t word;
		word = waddr[15:0] ^ ROM_XOR;
		return odd ? word[15:8] : word[7:0];
	endfunction

	task automatic check_sdram_addr(input string name, input gb_cart_pkg::sdram_addr_t got,
		input gb_cart_pkg::sdram_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input gb_cart_pkg::cart_byte_t got,
		input gb_cart_pkg::cart_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// bus drivers change inputs 1 ns after the rising edge
	// ------------------------------------------------------------------------
	task automatic dl_write(input logic [`DL_ADDR_W-1:0] addr, input gb_cart_pkg::rom_word_t data);
		@(posedge clk_sys);
		#1;
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		dl_wr = 1'b0;
	endtask

	task automatic load_header(input gb_cart_pkg::cart_byte_t mbc_type,
		input gb_cart_pkg::cart_byte_t rom_size, input gb_cart_pkg::cart_byte_t ram_size);
		@(posedge clk_sys);
		#1;
		dl_active = 1'b1;
		dl_write(`DL_ADDR_W'(`HDR_CGB), 16'h0000);  // dmg only image
		dl_write(`DL_ADDR_W'(`HDR_MBC), {mbc_type, 8'h00});
		dl_write(`DL_ADDR_W'(`HDR_SIZES), {ram_size, rom_size});
		@(posedge clk_sys);
		#1;
		dl_active = 1'b0;
		repeat (2) @(posedge clk_sys);  // cart_ready one cycle after the falling edge
		#1;
	endtask

	task automatic cpu_write(input gb_cart_pkg::cart_addr_t addr, input gb_cart_pkg::cart_byte_t data);
		@(posedge clk_sys);
		#1;
		cart_addr = addr;
		cart_di   = data;
		cart_wr   = 1'b1;
		#1;
		check_strobe("sdram_rd", sdram_rd, 1'b0);  // no rom fetch on a write
		@(posedge clk_sys);
		#1;
		cart_wr = 1'b0;
	endtask

	task automatic cpu_read(input gb_cart_pkg::cart_addr_t addr, output gb_cart_pkg::cart_byte_t data,
		output gb_cart_pkg::sdram_addr_t waddr, output logic rd_seen);
		@(posedge clk_sys);
		#1;
		cart_addr = addr;
		cart_rd   = 1'b1;
		#1;
		waddr   = sdram_addr;  // combinational and settled mid cycle
		rd_seen = sdram_rd;
		@(posedge clk_sys);
		#1;
		cart_rd = 1'b0;
		data    = cart_do;     // registered one cycle after the strobe
	endtask

	task automatic rom_check(input gb_cart_pkg::cart_addr_t addr, input logic [8:0] bank);
		gb_cart_pkg::sdram_addr_t exp_addr;
		gb_cart_pkg::sdram_addr_t got_addr;
		gb_cart_pkg::cart_byte_t  got_byte;
		logic                     got_rd;
		exp_addr = expected_word_addr(addr, bank);
		cpu_read(addr, got_byte, got_addr, got_rd);
		check_strobe("sdram_rd", got_rd, 1'b1);
		check_sdram_addr("sdram_addr", got_addr, exp_addr);
		check_byte("cart_do", got_byte, rom_model_byte(exp_addr, addr[0]));
	endtask

	task automatic read_check(input gb_cart_pkg::cart_addr_t addr, input gb_cart_pkg::cart_byte_t exp);
		gb_cart_pkg::sdram_addr_t got_addr;
		gb_cart_pkg::cart_byte_t  got_byte;
		logic                     got_rd;
		cpu_read(addr, got_byte, got_addr, got_rd);
		check_strobe("sdram_rd", got_rd, !addr[15]);  // rom fetch below 8000 only
		check_byte("cart_do", got_byte, exp);
	endtask

	task automatic pulse_reset();
		@(posedge clk_sys);
		#1;
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_first_load();
		logic [15:0] r;
		read_check(16'h0150, 8'h00);  // nothing loaded yet
		load_header(8'h00, 8'h00, 8'h00);
		for (int i = 0; i < 6; i++) begin
			random_bits(15, r);
			rom_check({1'b0, r[14:0]}, 9'd1);  // flat 32 KB
		end
	endtask

	task automatic test_mbc1_banking();
		load_header(8'h01, 8'h02, 8'h00);  // 8 banks
		cpu_write(16'h2100, 8'h0D);
		rom_check(16'h7F01, 9'd13 & 9'd7);  // mirrored by rom size
		cpu_write(16'h2000, 8'h00);
		rom_check(16'h4ABC, 9'd1);          // bank 0 reads as 1
		rom_check(16'h1235, 9'd1);
		load_header(8'h01, 8'h06, 8'h00);  // 128 banks
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'h2000, 8'h03);
		rom_check(16'h6543, {2'b00, 2'b10, 5'd3});  // ram bank as bits 6:5
		cpu_write(16'h6000, 8'h01);
		rom_check(16'h6543, 9'd3);          // mode 1 keeps the low bits only
	endtask

	task automatic test_mbc5_banking();
		load_header(8'h19, 8'h08, 8'h00);  // 512 banks
		rom_check(16'h4002, 9'd1);
		cpu_write(16'h2000, 8'h00);
		rom_check(16'h5003, 9'd0);          // bank 0 allowed
		cpu_write(16'h2FFF, 8'hA7);
		cpu_write(16'h3000, 8'h01);
		rom_check(16'h6ACE, 9'h1A7);
		rom_check(16'h0ACE, 9'h1A7);
		cpu_write(16'h3FFF, 8'h00);
		rom_check(16'h7FFF, 9'h0A7);
	endtask

	task automatic test_cart_ram();
		logic [15:0]             r;
		logic [12:0]             offs;
		gb_cart_pkg::cart_byte_t bank0_data [2];
		gb_cart_pkg::cart_byte_t bank2_data [2];
		load_header(8'h13, 8'h01, 8'h03);  // mbc3 with four ram banks
		random_bits(13, r);
		offs = r[12:0];
		read_check({3'b101, offs}, 8'hFF);  // ram still closed
		cpu_write(16'h0000, {4'h5, `RAM_ENABLE_KEY});
		for (int i = 0; i < 2; i++) begin
			random_bits(8, r);
			bank0_data[i] = r[7:0];
			random_bits(8, r);
			bank2_data[i] = r[7:0];
			if (bank2_data[i] == bank0_data[i])
				bank2_data[i] = ~bank2_data[i];  // banks must hold different bytes
		end
		cpu_write(16'h4000, 8'h00);
		cpu_write({3'b101, offs}, bank0_data[0]);
		cpu_write({3'b101, offs ^ 13'h1555}, bank0_data[1]);
		cpu_write(16'h4000, 8'h02);
		cpu_write({3'b101, offs}, bank2_data[0]);
		cpu_write({3'b101, offs ^ 13'h1555}, bank2_data[1]);
		read_check({3'b101, offs}, bank2_data[0]);
		read_check({3'b101, offs ^ 13'h1555}, bank2_data[1]);
		cpu_write(16'h4000, 8'h00);
		read_check({3'b101, offs}, bank0_data[0]);
		read_check({3'b101, offs ^ 13'h1555}, bank0_data[1]);
		cpu_write(16'h4000, 8'h08);  // rtc register select
		read_check({3'b101, offs}, 8'h00);
		cpu_write(16'h4000, 8'h00);
		read_check({3'b101, offs}, bank0_data[0]);
		cpu_write(16'h0000, 8'h00);
		read_check({3'b101, offs}, 8'hFF);
	endtask

	task automatic test_mbc2_nibbles();
		logic [15:0]             r;
		logic [8:0]              offs;
		gb_cart_pkg::cart_byte_t data;
		load_header(8'h06, 8'h03, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 3; i++) begin
			random_bits(9, r);
			offs = r[8:0];
			random_bits(7, r);
			data = {1'b0, r[6:0]};  // bit 7 clear keeps the upper nibble off F
			cpu_write({7'b1010000, offs}, data);
			read_check({7'b1010000, offs}, {4'hF, data[3:0]});  // 4 bit cells
		end
	endtask

	task automatic test_reset_and_reload();
		gb_cart_pkg::sdram_addr_t got_addr;
		gb_cart_pkg::cart_byte_t  got_byte;
		logic                     got_rd;
		load_header(8'h03, 8'h05, 8'h02);  // mbc1 with 8 KB ram
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h2000, 8'h06);
		cpu_write(16'hA010, 8'h3C);
		rom_check(16'h4100, 9'd6);
		read_check(16'hA010, 8'h3C);
		pulse_reset();
		// not loaded after reset so only the address path shows the bank
		cpu_read(16'h4100, got_byte, got_addr, got_rd);
		check_strobe("sdram_rd", got_rd, 1'b1);
		check_sdram_addr("sdram_addr", got_addr, expected_word_addr(16'h4100, 9'd1));
		check_byte("cart_do", got_byte, 8'h00);
		load_header(8'h03, 8'h05, 8'h02);
		rom_check(16'h4100, 9'd1);
		read_check(16'hA010, 8'hFF);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h2000, 8'h06);
		load_header(8'h03, 8'h05, 8'h02);  // new download without reset
		rom_check(16'h4100, 9'd1);
		read_check(16'hA010, 8'hFF);
	endtask

	initial begin : watchdog
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("timeout after %0d ns, the tests did not finish", 2 * RUN_CYCLES * CLK_PERIOD);
		$display("Checks failed");
		$finish;
	end

	initial begin
		clk_sys    = 1'b0;
		reset      = 1'b1;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_addr    = '0;
		dl_data    = '0;
		cart_addr  = '0;
		cart_di    = '0;
		cart_rd    = 1'b0;
		cart_wr    = 1'b0;
		errors     = 0;
		checks     = 0;
		lfsr_state = 16'd34459;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		test_first_load();
		test_mbc1_banking();
		test_mbc5_banking();
		test_cart_ram();
		test_mbc2_nibbles();
		test_reset_and_reload();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: verilog/cart_bus_if.sv
`timescale 1ns/1ns

// cpu cartridge bus, shared by all cart blocks
// rd and wr are one cycle strobes, never both high
interface cart_bus_if;

	gb_cart_pkg::cart_addr_t addr;   // cpu address
	gb_cart_pkg::cart_byte_t wdata;  // cpu write data
	logic                    rd;     // read strobe
	logic                    wr;     // write strobe

	// driver side at the top level
	modport cpu (
		output addr, wdata, rd, wr
	);

	// bank register writes
	modport regs (
		input addr, wdata, wr
	);

	// rom address path
	modport rom (
		input addr, rd
	);

	// cartridge ram and read data
	modport ram (
		input addr, wdata, rd, wr
	);

endinterface

// File: verilog/cart_header_capture.sv
`timescale 1ns/1ns
`include "gb_cart_defs.svh"

module cart_header_capture (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,   // rom download in progress
	input  logic                    dl_wr,       // one word strobe
	input  logic [`DL_ADDR_W-1:0]   dl_addr,     // byte address, even
	input  gb_cart_pkg::rom_word_t  dl_data,
	output gb_cart_pkg::cart_info_t info,
	output logic                    cart_ready   // image loaded at least once
);

	gb_cart_pkg::cart_byte_t mbc_type;  // 0x147
	gb_cart_pkg::cart_byte_t rom_size;  // 0x148
	gb_cart_pkg::cart_byte_t ram_size;  // 0x149
	logic                    dl_active_q;

	// ------------------------------------------------------------------------
	// header bytes, snooped from the download stream
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (dl_active && dl_wr) begin
			if (dl_addr == `HDR_MBC)
				mbc_type <= dl_data[15:8];
			if (dl_addr == `HDR_SIZES) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// end of download arms the cartridge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			cart_ready  <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active_q && !dl_active)  // falling edge
				cart_ready <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	always_comb begin
		case (mbc_type)
			8'h01, 8'h02, 8'h03:                      info.kind = gb_cart_pkg::MBC_1;
			8'h05, 8'h06:                             info.kind = gb_cart_pkg::MBC_2;
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:        info.kind = gb_cart_pkg::MBC_3;
			8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: info.kind = gb_cart_pkg::MBC_5;
			default:                                  info.kind = gb_cart_pkg::MBC_NONE;
		endcase

		// 2 << size banks, odd sizes like 0x52 fall back to 128
		if (rom_size <= 8'd8)
			info.rom_mask = ~(9'h1FF << (rom_size[3:0] + 4'd1));
		else
			info.rom_mask = 9'd127;

		if (ram_size == 8'd3)
			info.ram_mask = 4'h3;  // 32 KB, four banks
		else if (ram_size >= 8'd4)
			info.ram_mask = 4'hF;  // 128 KB
		else
			info.ram_mask = 4'h0;  // single bank or none

		case (mbc_type)
			8'h03, 8'h06, 8'h09, 8'h0D, 8'h0F, 8'h10, 8'h13,
			8'h1B, 8'h1E, 8'h22, 8'hFF: info.battery = 1'b1;
			default:                    info.battery = 1'b0;
		endcase
	end

endmodule

// File: verilog/cart_ram.sv
`timescale 1ns/1ns
`include "gb_cart_defs.svh"

module cart_ram (
	input  logic                     clk_sys,
	input  logic                     reset,
	cart_bus_if.ram                  bus,
	input  gb_cart_pkg::cart_info_t  info,
	input  gb_cart_pkg::bank_state_t banks,
	input  logic                     cart_ready,
	input  gb_cart_pkg::cart_byte_t  rom_byte,
	output gb_cart_pkg::cart_byte_t  cart_do
);

	// what the last read returns
	typedef enum logic [2:0] {SEL_ZERO, SEL_ROM, SEL_FF, SEL_NIB, SEL_RAM} rd_sel_t;

	gb_cart_pkg::cart_byte_t mem [0:(1<<`CRAM_ADDR_W)-1];
	gb_cart_pkg::cart_byte_t mem_q;
	gb_cart_pkg::cart_byte_t rom_q;
	rd_sel_t                 sel_q;
	logic [`RAM_BANK_W-1:0]  bank;
	logic [`CRAM_ADDR_W-1:0] cram_addr;
	logic                    is_cram;   // a000..bfff
	logic                    nib_area;  // mbc2 4 bit cells

	always_comb begin
		case (info.kind)
			gb_cart_pkg::MBC_1: bank = (banks.mbc1_mode ? banks.ram_bank : 4'd0) & info.ram_mask;
			gb_cart_pkg::MBC_3,
			gb_cart_pkg::MBC_5: bank = banks.ram_bank & info.ram_mask;
			default:            bank = '0;  // single bank
		endcase
	end

	assign cram_addr = {bank, bus.addr[12:0]};
	assign is_cram   = (bus.addr[15:13] == 3'b101);
	assign nib_area  = (info.kind == gb_cart_pkg::MBC_2) && (bus.addr[15:9] == 7'b1010000);

	// ------------------------------------------------------------------------
	// storage, read data captured on the rd strobe
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (bus.wr && is_cram && banks.ram_enable)
			mem[cram_addr] <= bus.wdata;
		if (bus.rd) begin
			mem_q <= mem[cram_addr];
			rom_q <= rom_byte;  // rom word only valid during rd
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q <= SEL_ZERO;
		end else if (bus.rd) begin
			if (!cart_ready)
				sel_q <= SEL_ZERO;  // nothing loaded yet
			else if (!is_cram)
				sel_q <= SEL_ROM;
			else if (!banks.ram_enable)
				sel_q <= SEL_FF;    // open bus
			else if (banks.rtc_mode)
				sel_q <= SEL_ZERO;  // no rtc, reads as 0
			else if (nib_area)
				sel_q <= SEL_NIB;
			else
				sel_q <= SEL_RAM;
		end
	end

	always_comb begin
		case (sel_q)
			SEL_ROM: cart_do = rom_q;
			SEL_FF:  cart_do = 8'hFF;
			SEL_NIB: cart_do = {4'hF, mem_q[3:0]};  // upper nibble floats high
			SEL_RAM: cart_do = mem_q;
			default: cart_do = 8'h00;
		endcase
	end

endmodule

// File: verilog/gb_cart_defs.svh
`ifndef GB_CART_DEFS_SVH
`define GB_CART_DEFS_SVH

// ------------------------------------------------------------------------
// bus widths
// ------------------------------------------------------------------------

`define CART_ADDR_W     16  // cpu side cartridge address
`define SDRAM_ADDR_W    24  // 16 bit word address into sdram
`define DL_ADDR_W       25  // byte address of the rom download
`define CRAM_ADDR_W     17  // 128 KB cartridge ram, 16 banks of 8 KB

`define ROM_BANK_W      9   // up to 512 banks on mbc5
`define RAM_BANK_W      4   // up to 16 ram banks

// ------------------------------------------------------------------------
// header locations
// ------------------------------------------------------------------------

// download delivers 16 bit words at even byte addresses,
// high byte holds the odd address
`define HDR_CGB         'h142  // high byte is the cgb flag at 0x143
`define HDR_MBC         'h146  // high byte is the cartridge type at 0x147
`define HDR_SIZES       'h148  // low byte rom size, high byte ram size

// magic nibble that opens cartridge ram for access
`define RAM_ENABLE_KEY  4'hA

`endif

// File: verilog/gb_cart_mapper.sv
`timescale 1ns/1ns
`include "gb_cart_defs.svh"

module gb_cart_mapper (
	input  logic                     clk_sys,
	input  logic                     reset,

	// rom download
	input  logic                     dl_active,
	input  logic                     dl_wr,
	input  logic [`DL_ADDR_W-1:0]    dl_addr,
	input  gb_cart_pkg::rom_word_t   dl_data,

	// cpu cartridge bus
	input  gb_cart_pkg::cart_addr_t  cart_addr,
	input  gb_cart_pkg::cart_byte_t  cart_di,
	input  logic                     cart_rd,
	input  logic                     cart_wr,
	output gb_cart_pkg::cart_byte_t  cart_do,

	// external rom storage
	output gb_cart_pkg::sdram_addr_t sdram_addr,
	output logic                     sdram_rd,
	input  gb_cart_pkg::rom_word_t   rom_data
);

	gb_cart_pkg::cart_info_t  info;
	gb_cart_pkg::bank_state_t banks;
	gb_cart_pkg::cart_byte_t  rom_byte;
	logic                     cart_ready;

	cart_bus_if bus ();

	assign bus.addr  = cart_addr;
	assign bus.wdata = cart_di;
	assign bus.rd    = cart_rd;
	assign bus.wr    = cart_wr;

	cart_header_capture cart_header_capture_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_active  (dl_active),
		.dl_wr      (dl_wr),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.info       (info),
		.cart_ready (cart_ready)
	);

	mbc_registers mbc_registers_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.bus       (bus.regs),
		.info      (info),
		.banks     (banks)
	);

	rom_bank_mapper rom_bank_mapper_inst (
		.bus        (bus.rom),
		.info       (info),
		.banks      (banks),
		.sdram_addr (sdram_addr),
		.sdram_rd   (sdram_rd),
		.rom_byte   (rom_byte),
		.rom_data   (rom_data)
	);

	cart_ram cart_ram_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus.ram),
		.info       (info),
		.banks      (banks),
		.cart_ready (cart_ready),
		.rom_byte   (rom_byte),
		.cart_do    (cart_do)
	);

endmodule

// File: verilog/gb_cart_pkg.sv
`include "gb_cart_defs.svh"

package gb_cart_pkg;

	// mapper family, decoded from the cartridge type byte
	typedef enum logic [2:0] {
		MBC_NONE,   // plain 32 KB rom
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_t;

	// cartridge description taken from the header
	typedef struct packed {
		mbc_kind_t                 kind;
		logic [`ROM_BANK_W-1:0]    rom_mask;  // mirrors banks beyond rom size
		logic [`RAM_BANK_W-1:0]    ram_mask;  // mirrors ram banks
		logic                      battery;   // battery backed type
	} cart_info_t;

	typedef logic [`CART_ADDR_W-1:0]  cart_addr_t;
	typedef logic [7:0]               cart_byte_t;
	typedef logic [15:0]              rom_word_t;
	typedef logic [`SDRAM_ADDR_W-1:0] sdram_addr_t;

	// live banking state written by the cpu
	typedef struct packed {
		logic [`ROM_BANK_W-1:0] rom_bank;
		logic [`RAM_BANK_W-1:0] ram_bank;
		logic                   mbc1_mode;   // 1 selects ram banking on mbc1
		logic                   rtc_mode;    // mbc3 rtc register mapped at a000
		logic                   ram_enable;
	} bank_state_t;

endpackage

// File: verilog/mbc_registers.sv
`timescale 1ns/1ns
`include "gb_cart_defs.svh"

module mbc_registers (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     dl_active,  // new image, back to power-on state
	cart_bus_if.regs                 bus,
	input  gb_cart_pkg::cart_info_t  info,
	output gb_cart_pkg::bank_state_t banks
);

	logic is_mbc1;
	logic is_mbc3;
	logic is_mbc5;

	assign is_mbc1 = (info.kind == gb_cart_pkg::MBC_1);
	assign is_mbc3 = (info.kind == gb_cart_pkg::MBC_3);
	assign is_mbc5 = (info.kind == gb_cart_pkg::MBC_5);

	// ------------------------------------------------------------------------
	// register writes, decoded on a[15:13]
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			banks.rom_bank   <= 9'd1;  // bank 1 in the switchable window
			banks.ram_bank   <= 4'd0;
			banks.mbc1_mode  <= 1'b0;
			banks.rtc_mode   <= 1'b0;
			banks.ram_enable <= 1'b0;
		end else if (bus.wr) begin
			case (bus.addr[15:13])
				// 0000..1FFF ram enable
				3'b000: banks.ram_enable <= (bus.wdata[3:0] == `RAM_ENABLE_KEY);

				// 2000..3FFF rom bank
				3'b001: begin
					if (is_mbc5) begin
						if (bus.addr[12])
							banks.rom_bank[8] <= bus.wdata[0];  // 3000..3FFF bit 8
						else
							banks.rom_bank[7:0] <= bus.wdata;   // low byte, 0 allowed
					end else if (bus.wdata[6:0] == 7'd0) begin
						banks.rom_bank <= 9'd1;  // bank 0 reads as 1
					end else begin
						banks.rom_bank <= {2'b00, bus.wdata[6:0]};
					end
				end

				// 4000..5FFF ram bank or rtc select
				3'b010: begin
					if (is_mbc3) begin
						if (bus.wdata[3]) begin
							banks.rtc_mode <= 1'b1;
						end else begin
							banks.rtc_mode <= 1'b0;
							banks.ram_bank <= {2'b00, bus.wdata[1:0]};
						end
					end else if (is_mbc5) begin
						banks.ram_bank <= bus.wdata[3:0];  // 16 banks
					end else begin
						banks.ram_bank <= {2'b00, bus.wdata[1:0]};
					end
				end

				// 6000..7FFF banking mode
				3'b011: begin
					if (is_mbc1)
						banks.mbc1_mode <= bus.wdata[0];
				end

				default: ;  // a000 and up belong to cart ram
			endcase
		end
	end

endmodule

// File: verilog/rom_bank_mapper.sv
`timescale 1ns/1ns
`include "gb_cart_defs.svh"

module rom_bank_mapper (
	cart_bus_if.rom                  bus,
	input  gb_cart_pkg::cart_info_t  info,
	input  gb_cart_pkg::bank_state_t banks,
	output gb_cart_pkg::sdram_addr_t sdram_addr,
	output logic                     sdram_rd,
	output gb_cart_pkg::cart_byte_t  rom_byte,
	input  gb_cart_pkg::rom_word_t   rom_data    // valid in the same cycle
);

	logic [6:0]             mbc1_bank;  // ram bank bits on top in mode 0
	logic [`ROM_BANK_W-1:0] bank;       // masked for mirroring
	logic [9:0]             field;      // 16 KB bank and 8 KB half

	always_comb begin
		mbc1_bank = {banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0], banks.rom_bank[4:0]};

		case (info.kind)
			gb_cart_pkg::MBC_1: bank = {2'b00, mbc1_bank & info.rom_mask[6:0]};
			gb_cart_pkg::MBC_2: bank = {5'd0, banks.rom_bank[3:0] & info.rom_mask[3:0]};
			gb_cart_pkg::MBC_3: bank = {2'b00, banks.rom_bank[6:0] & info.rom_mask[6:0]};
			gb_cart_pkg::MBC_5: bank = banks.rom_bank & info.rom_mask;  // bank 0 allowed
			default:            bank = '0;
		endcase

		if (info.kind == gb_cart_pkg::MBC_NONE)
			field = {8'd0, bus.addr[14:13]};      // 32 KB linear
		else if (bus.addr[15:14] == 2'b01)
			field = {bank, bus.addr[13]};         // switchable window at 4000
		else
			field = {9'd0, bus.addr[13]};         // fixed bank 0
	end

	// word address, byte lane picked below
	assign sdram_addr = {{(`SDRAM_ADDR_W-22){1'b0}}, field, bus.addr[12:1]};
	assign sdram_rd   = bus.rd && !bus.addr[15];  // only 0000..7FFF is rom

	assign rom_byte = bus.addr[0] ? rom_data[15:8] : rom_data[7:0];

endmodule
